// File: build.f
rob_cfg_pkg.sv
rv32i_pkg.sv
rob_ifs.sv
rob_dispatch.sv
rob_writeback.sv
rob_queue.sv
rob_commit.sv
rob_top.sv
rob_props.sv
tb_rob_top.sv

// File: Bender.yml
package:
  name: rob

sources:
  - rob_cfg_pkg.sv
  - rv32i_pkg.sv
  - rob_ifs.sv
  - rob_dispatch.sv
  - rob_writeback.sv
  - rob_queue.sv
  - rob_commit.sv
  - rob_top.sv
  - target: test
    files:
      - rob_props.sv
      - tb_rob_top.sv

// File: tb_rob_top.sv
`timescale 1ns/10ps

module tb_rob_top;
    import rob_cfg_pkg::*;
    import rv32i_pkg::*;

    localparam int n_tests      = 6;
    localparam int ops_per_test = 200;
    localparam int clk_period   = 40;

    logic clk, rst, enqueue_valid, regf_we;
    logic alu_valid, br_valid, br_pc_select;
    logic [preg_w-1:0] phys_reg, retire_pd;
    logic [areg_w-1:0] arch_reg, rs1_s, rs2_s;
    logic [areg_w-1:0] retire_rd_addr, retire_rs1_addr, retire_rs2_addr;
    logic [xlen-1:0] inst, pc_rdata, pc_wdata, alu_rd_wdata, br_rd_wdata, br_pc_branch;
    rob_idx_t alu_idx, br_idx, rob_idx;
    logic full, retire_valid, retire_regf_we, redirect_valid;
    logic [order_w-1:0] retire_order;
    logic [xlen-1:0] retire_pc_rdata, retire_pc_wdata, retire_inst, retire_rd_wdata, redirect_addr;

    integer seed;
    int     errors;
    int     tests_ok;
    int     tests_bad;
    int     op_next;

    // reference model with one expected entry per slot
    rob_entry_t         m_ent [rob_depth];
    int                 m_head;
    int                 m_count;
    logic [order_w-1:0] m_order;

    opcode_e op_list [9] = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                             op_load, op_store, op_imm, op_reg};

    rob_top u_dut (.*);

    bind rob_queue rob_props u_props (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .tail_busy   (mem[tail_idx].valid),
        .full        (full),
        .retire      (head.retire),
        .flush       (head.flush)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // compare mismatches plus failed queue assertions
    function automatic int fault_count();
        return errors + u_dut.u_queue.u_props.fails;
    endfunction

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic clear_model();
        foreach (m_ent[i]) begin
            m_ent[i] = '0;
        end
        m_head  = 0;
        m_count = 0;
    endtask

    // expected entry for the instruction now on the inputs
    function automatic rob_entry_t decode_expect();
        rob_entry_t e;
        logic [6:0] op;
        op         = inst[6:0];
        e          = '0;
        e.valid    = 1'b1;
        e.is_nop   = (inst == 32'h0000_0013);
        e.pd       = phys_reg;
        e.regf_we  = regf_we;
        e.pc_rdata = pc_rdata;
        e.pc_wdata = pc_wdata;
        e.inst     = inst;
        e.rd_addr  = (op == op_store) ? '0 : arch_reg;
        e.rs1_addr = (op == op_lui || op == op_auipc || op == op_jal) ? '0 : rs1_s;
        e.rs2_addr = (op == op_imm || op == op_lui || op == op_auipc || op == op_load ||
                      op == op_jal || op == op_jalr) ? '0 : rs2_s;
        return e;
    endfunction

    task automatic check_outputs();
        rob_entry_t e;
        logic       exp_ret;
        e       = m_ent[m_head];
        exp_ret = (m_count > 0) && e.done;
        check_equal(full, m_count == rob_depth, "full");
        check_equal(rob_idx, (m_head + m_count) % rob_depth, "rob_idx");
        check_equal(retire_valid, exp_ret, "retire_valid");
        if (exp_ret && retire_valid) begin
            check_equal(retire_order, m_order, "retire_order");
            check_equal(retire_pc_rdata, e.pc_rdata, "retire_pc_rdata");
            check_equal(retire_pc_wdata, e.pc_wdata, "retire_pc_wdata");
            check_equal(retire_inst, e.inst, "retire_inst");
            check_equal(retire_pd, e.pd, "retire_pd");
            check_equal(retire_rd_addr, e.rd_addr, "retire_rd_addr");
            check_equal(retire_rs1_addr, e.rs1_addr, "retire_rs1_addr");
            check_equal(retire_rs2_addr, e.rs2_addr, "retire_rs2_addr");
            check_equal(retire_regf_we, e.regf_we, "retire_regf_we");
            check_equal(retire_rd_wdata, e.is_nop ? 32'd0 : e.rd_wdata, "retire_rd_wdata");
            check_equal(redirect_valid, e.redirect, "redirect_valid");
            if (e.redirect) begin
                check_equal(redirect_addr, e.redirect_addr, "redirect_addr");
            end
        end else begin
            check_equal(redirect_valid, 1'b0, "redirect_valid");
        end
    endtask

    // check at the falling edge, drive, then step the model
    task automatic run_cycle(input bit enq, input bit nop, input bit use_alu,
                             input bit use_br, input bit taken, input bit at_head,
                             input bit same_idx);
        int cand [$];
        int alu_pick;
        int br_pick;
        int k;
        bit was_full;
        bit retired;
        @(negedge clk);
        check_outputs();
        alu_pick = -1;
        br_pick  = -1;
        for (int i = 0; i < m_count; i++) begin
            k = (m_head + i) % rob_depth;
            if (!m_ent[k].done) begin
                cand.push_back(k);
            end
        end
        if (use_br && cand.size() > 0) begin
            k       = at_head ? 0 : pick(cand.size());
            br_pick = cand[k];
            cand.delete(k);
        end
        if (use_alu && cand.size() > 0) begin
            alu_pick = cand[(at_head && !use_br) ? 0 : pick(cand.size())];
        end
        if (same_idx && br_pick >= 0) begin
            alu_pick = br_pick;
        end

        enqueue_valid = enq;
        phys_reg      = $random(seed);
        arch_reg      = $random(seed);
        rs1_s         = $random(seed);
        rs2_s         = $random(seed);
        pc_rdata      = $random(seed);
        pc_wdata      = $random(seed);
        regf_we       = $random(seed);
        inst          = $random(seed);
        if (nop) begin
            inst = 32'h0000_0013;
        end else begin
            inst[6:0] = op_list[op_next % 9];
            if (enq) begin
                op_next++;
            end
        end
        alu_valid    = (alu_pick >= 0);
        alu_idx      = rob_idx_t'(alu_pick);
        alu_rd_wdata = $random(seed) | 32'h1;
        br_valid     = (br_pick >= 0);
        br_idx       = rob_idx_t'(br_pick);
        br_rd_wdata  = $random(seed) | 32'h1;
        br_pc_select = taken;
        br_pc_branch = $random(seed) & 32'hffff_fffc;

        was_full = (m_count == rob_depth);
        retired  = (m_count > 0) && m_ent[m_head].done;
        if (retired) begin
            m_order++;
        end
        if (retired && m_ent[m_head].redirect) begin
            clear_model();
        end else begin
            if (alu_valid) begin
                m_ent[alu_pick].done     = 1'b1;
                m_ent[alu_pick].rd_wdata = alu_rd_wdata;
            end
            // branch data lands last so it wins a shared slot
            if (br_valid) begin
                m_ent[br_pick].done          = 1'b1;
                m_ent[br_pick].rd_wdata      = br_rd_wdata;
                m_ent[br_pick].redirect      = taken;
                m_ent[br_pick].redirect_addr = taken ? br_pc_branch : '0;
            end
            if (enq && !was_full) begin
                m_ent[(m_head + m_count) % rob_depth] = decode_expect();
                m_count++;
            end
            if (retired) begin
                m_ent[m_head] = '0;
                m_head        = (m_head + 1) % rob_depth;
                m_count--;
            end
        end
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while (m_count > 0 && guard < 64) begin
            run_cycle(0, 0, 1, 0, 0, 0, 0);
            guard++;
        end
        run_cycle(0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (fault_count() == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, fault_count() - errs_before);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          e0;
        seed      = 82584;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        op_next   = 0;
        m_order   = '0;
        clk       = 1'b0;
        rst       = 1'b1;
        {enqueue_valid, regf_we, alu_valid, br_valid, br_pc_select} = '0;
        {phys_reg, arch_reg, rs1_s, rs2_s, alu_idx, br_idx} = '0;
        {inst, pc_rdata, pc_wdata} = '0;
        {alu_rd_wdata, br_rd_wdata, br_pc_branch} = '0;
        clear_model();
        repeat (3) @(negedge clk);
        rst = 1'b0;

        e0 = fault_count();
        for (int i = 0; i < 120; i++) begin
            run_cycle(i % 3 != 2, 0, 1, 0, 0, 0, 0);
        end
        drain();
        report_test("decode masking", e0);

        // random mix of enqueues and completions on both buses
        e0 = fault_count();
        for (int i = 0; i < 150; i++) begin
            r = $random(seed);
            run_cycle(r[0], 0, r[1], r[2], 0, 0, 0);
        end
        drain();
        report_test("out of order completion", e0);

        e0 = fault_count();
        repeat (4) run_cycle(1, 1, 0, 0, 0, 0, 0);
        drain();
        report_test("nop handling", e0);

        // fill up, try two more, then free one slot
        e0 = fault_count();
        repeat (rob_depth + 2) run_cycle(1, 0, 0, 0, 0, 0, 0);
        run_cycle(0, 0, 1, 0, 0, 1, 0);
        run_cycle(0, 0, 0, 0, 0, 0, 0);
        run_cycle(1, 0, 0, 0, 0, 0, 0);
        drain();
        report_test("full and refusal", e0);

        // taken branch at the head with younger entries behind it
        e0 = fault_count();
        repeat (4) run_cycle(1, 0, 0, 0, 0, 0, 0);
        run_cycle(0, 0, 1, 1, 1, 1, 0);
        run_cycle(1, 0, 1, 0, 0, 0, 0);
        run_cycle(1, 0, 0, 0, 0, 0, 0);
        drain();
        report_test("redirect flush", e0);

        e0 = fault_count();
        repeat (3) run_cycle(1, 0, 0, 0, 0, 0, 0);
        run_cycle(0, 0, 1, 1, 0, 0, 1);
        drain();
        report_test("same index collision", e0);

        $display("summary: %0d tests passed, %0d tests failed, %0d assertion failures",
                 tests_ok, tests_bad, u_dut.u_queue.u_props.fails);
        if (fault_count() == 0 && tests_bad == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((n_tests * ops_per_test + 50) * clk_period);
        $display("timeout: the run did not finish within %0d clock cycles",
                 n_tests * ops_per_test + 50);
        $display(">>> FAIL");
        $finish;
    end

endmodule : tb_rob_top

// File: rob_props.sv
`timescale 1ns/10ps

// queue checks bound into rob_queue
module rob_props (
    input logic clk,
    input logic rst,
    input logic alloc_valid,
    input logic tail_busy,
    input logic full,
    input logic retire,
    input logic flush
);

    // count of failed assertions
    int fails = 0;

    // an allocation always lands on a free slot
    no_write_when_full: assert property (
        @(posedge clk) disable iff (rst) alloc_valid |-> !tail_busy
    ) else begin
        $error("allocation written over a live entry of a full buffer");
        fails++;
    end

    // flush leaves the buffer empty
    flush_clears_full: assert property (
        @(posedge clk) disable iff (rst) flush |=> !full
    ) else begin
        $error("full still set one cycle after a flush");
        fails++;
    end

    // nothing is done right out of reset
    no_retire_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !retire
    ) else begin
        $error("retire raised in the first cycle after reset");
        fails++;
    end

endmodule : rob_props

// File: rob_top.sv
`timescale 1ns/10ps

module rob_top (
    input  logic                             clk,
    input  logic                             rst,

    // dispatch
    input  logic                             enqueue_valid,
    input  logic [rob_cfg_pkg::preg_w-1:0]   phys_reg,
    input  logic [rob_cfg_pkg::areg_w-1:0]   arch_reg,
    input  logic [rob_cfg_pkg::areg_w-1:0]   rs1_s,
    input  logic [rob_cfg_pkg::areg_w-1:0]   rs2_s,
    input  logic [rob_cfg_pkg::xlen-1:0]     inst,
    input  logic [rob_cfg_pkg::xlen-1:0]     pc_rdata,
    input  logic [rob_cfg_pkg::xlen-1:0]     pc_wdata,
    input  logic                             regf_we,

    // alu completion
    input  logic                             alu_valid,
    input  rob_cfg_pkg::rob_idx_t            alu_idx,
    input  logic [rob_cfg_pkg::xlen-1:0]     alu_rd_wdata,

    // branch completion
    input  logic                             br_valid,
    input  rob_cfg_pkg::rob_idx_t            br_idx,
    input  logic [rob_cfg_pkg::xlen-1:0]     br_rd_wdata,
    input  logic                             br_pc_select,
    input  logic [rob_cfg_pkg::xlen-1:0]     br_pc_branch,

    output logic                             full,
    output rob_cfg_pkg::rob_idx_t            rob_idx,

    // retire
    output logic                             retire_valid,
    output logic [rob_cfg_pkg::order_w-1:0]  retire_order,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_pc_rdata,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_pc_wdata,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_inst,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_rd_wdata,
    output logic [rob_cfg_pkg::preg_w-1:0]   retire_pd,
    output logic [rob_cfg_pkg::areg_w-1:0]   retire_rd_addr,
    output logic [rob_cfg_pkg::areg_w-1:0]   retire_rs1_addr,
    output logic [rob_cfg_pkg::areg_w-1:0]   retire_rs2_addr,
    output logic                             retire_regf_we,

    output logic                             redirect_valid,
    output logic [rob_cfg_pkg::xlen-1:0]     redirect_addr
);
    import rv32i_pkg::*;

    logic       alloc_valid;
    rob_entry_t alloc_entry;

    rob_cdb_if  cdb ();
    rob_head_if head ();

    rob_dispatch u_dispatch (
        .enqueue_valid (enqueue_valid),
        .phys_reg      (phys_reg),
        .arch_reg      (arch_reg),
        .rs1_s         (rs1_s),
        .rs2_s         (rs2_s),
        .inst          (inst),
        .pc_rdata      (pc_rdata),
        .pc_wdata      (pc_wdata),
        .regf_we       (regf_we),
        .full          (full),
        .alloc_valid   (alloc_valid),
        .alloc_entry   (alloc_entry)
    );

    rob_writeback u_writeback (
        .alu_valid    (alu_valid),
        .alu_idx      (alu_idx),
        .alu_rd_wdata (alu_rd_wdata),
        .br_valid     (br_valid),
        .br_idx       (br_idx),
        .br_rd_wdata  (br_rd_wdata),
        .br_pc_select (br_pc_select),
        .br_pc_branch (br_pc_branch),
        .cdb          (cdb.src)
    );

    // rob_idx is the slot the next accepted enqueue lands in
    rob_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .full        (full),
        .tail_idx    (rob_idx),
        .cdb         (cdb.dst),
        .head        (head.dst)
    );

    rob_commit u_commit (
        .clk             (clk),
        .rst             (rst),
        .head            (head.src),
        .retire_valid    (retire_valid),
        .retire_order    (retire_order),
        .retire_pc_rdata (retire_pc_rdata),
        .retire_pc_wdata (retire_pc_wdata),
        .retire_inst     (retire_inst),
        .retire_rd_wdata (retire_rd_wdata),
        .retire_pd       (retire_pd),
        .retire_rd_addr  (retire_rd_addr),
        .retire_rs1_addr (retire_rs1_addr),
        .retire_rs2_addr (retire_rs2_addr),
        .retire_regf_we  (retire_regf_we),
        .redirect_valid  (redirect_valid),
        .redirect_addr   (redirect_addr)
    );

endmodule : rob_top

// File: rob_commit.sv
`timescale 1ns/10ps

module rob_commit (
    input  logic                             clk,
    input  logic                             rst,

    rob_head_if.src                          head,

    // retire record
    output logic                             retire_valid,
    output logic [rob_cfg_pkg::order_w-1:0]  retire_order,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_pc_rdata,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_pc_wdata,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_inst,
    output logic [rob_cfg_pkg::xlen-1:0]     retire_rd_wdata,
    output logic [rob_cfg_pkg::preg_w-1:0]   retire_pd,
    output logic [rob_cfg_pkg::areg_w-1:0]   retire_rd_addr,
    output logic [rob_cfg_pkg::areg_w-1:0]   retire_rs1_addr,
    output logic [rob_cfg_pkg::areg_w-1:0]   retire_rs2_addr,
    output logic                             retire_regf_we,

    // front end redirect
    output logic                             redirect_valid,
    output logic [rob_cfg_pkg::xlen-1:0]     redirect_addr
);
    import rob_cfg_pkg::*;

    logic [order_w-1:0] order_q;

    // head is ready once its result is in
    assign retire_valid = !head.empty && head.head_entry.valid && head.head_entry.done;
    assign head.retire  = retire_valid;

    assign retire_order    = order_q;
    assign retire_pc_rdata = head.head_entry.pc_rdata;
    assign retire_pc_wdata = head.head_entry.pc_wdata;
    assign retire_inst     = head.head_entry.inst;
    assign retire_pd       = head.head_entry.pd;
    assign retire_rd_addr  = head.head_entry.rd_addr;
    assign retire_rs1_addr = head.head_entry.rs1_addr;
    assign retire_rs2_addr = head.head_entry.rs2_addr;
    assign retire_regf_we  = head.head_entry.regf_we;

    // a nop never reports a write value
    assign retire_rd_wdata = head.head_entry.is_nop ? '0 : head.head_entry.rd_wdata;

    // taken branch at retire empties the buffer
    assign redirect_valid = retire_valid && head.head_entry.redirect;
    assign redirect_addr  = head.head_entry.redirect_addr;
    assign head.flush     = redirect_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            order_q <= '0;
        end else if (retire_valid) begin
            order_q <= order_q + 1'b1;
        end
    end

endmodule : rob_commit

// File: rob_queue.sv
`timescale 1ns/10ps

module rob_queue (
    input  logic                   clk,
    input  logic                   rst,

    // allocation from dispatch
    input  logic                   alloc_valid,
    input  rv32i_pkg::rob_entry_t  alloc_entry,
    output logic                   full,
    output rob_cfg_pkg::rob_idx_t  tail_idx,

    rob_cdb_if.dst                 cdb,
    rob_head_if.dst                head
);
    import rob_cfg_pkg::*;
    import rv32i_pkg::*;

    rob_entry_t mem [rob_depth];

    rob_ptr_t head_ptr;
    rob_ptr_t tail_ptr;
    rob_idx_t head_idx;

    assign head_idx = head_ptr[rob_idx_w-1:0];
    assign tail_idx = tail_ptr[rob_idx_w-1:0];

    // same slot, opposite lap
    assign full = (head_idx == tail_idx) && (head_ptr[rob_idx_w] != tail_ptr[rob_idx_w]);

    assign head.empty      = (head_ptr == tail_ptr);
    assign head.head_entry = mem[head_idx];

    always_ff @(posedge clk) begin
        if (rst || head.flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < rob_depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // new entry at the tail, dispatch already checked full
            if (alloc_valid) begin
                mem[tail_idx] <= alloc_entry;
                tail_ptr      <= tail_ptr + 1'b1;
            end

            // alu completion
            if (cdb.alu_valid && mem[cdb.alu_idx].valid) begin
                mem[cdb.alu_idx].done     <= 1'b1;
                mem[cdb.alu_idx].rd_wdata <= cdb.alu_rd_wdata;
            end

            // branch completion carries the redirect decision
            if (cdb.br_valid && mem[cdb.br_idx].valid) begin
                mem[cdb.br_idx].done          <= 1'b1;
                mem[cdb.br_idx].rd_wdata      <= cdb.br_rd_wdata;
                mem[cdb.br_idx].redirect      <= cdb.br_redirect;
                mem[cdb.br_idx].redirect_addr <= cdb.br_redirect_addr;
            end

            // retired head slot is freed
            if (head.retire) begin
                mem[head_idx] <= '0;
                head_ptr      <= head_ptr + 1'b1;
            end
        end
    end

endmodule : rob_queue

// File: rob_writeback.sv
`timescale 1ns/10ps

module rob_writeback (
    // alu completion
    input  logic                          alu_valid,
    input  rob_cfg_pkg::rob_idx_t         alu_idx,
    input  logic [rob_cfg_pkg::xlen-1:0]  alu_rd_wdata,

    // branch completion
    input  logic                          br_valid,
    input  rob_cfg_pkg::rob_idx_t         br_idx,
    input  logic [rob_cfg_pkg::xlen-1:0]  br_rd_wdata,
    input  logic                          br_pc_select,
    input  logic [rob_cfg_pkg::xlen-1:0]  br_pc_branch,

    rob_cdb_if.src                        cdb
);

    logic collide;
    logic take_redirect;

    // both buses on one slot, branch result is kept
    assign collide = alu_valid && br_valid && (alu_idx == br_idx);

    // redirect only recorded for a taken branch
    assign take_redirect = br_valid && br_pc_select;

    // alu slot
    assign cdb.alu_valid    = alu_valid && !collide;
    assign cdb.alu_idx      = alu_idx;
    assign cdb.alu_rd_wdata = alu_rd_wdata;

    // branch slot
    assign cdb.br_valid         = br_valid;
    assign cdb.br_idx           = br_idx;
    assign cdb.br_rd_wdata      = br_rd_wdata;
    assign cdb.br_redirect      = take_redirect;
    assign cdb.br_redirect_addr = take_redirect ? br_pc_branch : '0;

endmodule : rob_writeback

// File: rob_dispatch.sv
`timescale 1ns/10ps

module rob_dispatch (
    input  logic                            enqueue_valid,
    input  logic [rob_cfg_pkg::preg_w-1:0]  phys_reg,
    input  logic [rob_cfg_pkg::areg_w-1:0]  arch_reg,
    input  logic [rob_cfg_pkg::areg_w-1:0]  rs1_s,
    input  logic [rob_cfg_pkg::areg_w-1:0]  rs2_s,
    input  logic [rob_cfg_pkg::xlen-1:0]    inst,
    input  logic [rob_cfg_pkg::xlen-1:0]    pc_rdata,
    input  logic [rob_cfg_pkg::xlen-1:0]    pc_wdata,
    input  logic                            regf_we,
    input  logic                            full,
    output logic                            alloc_valid,
    output rv32i_pkg::rob_entry_t           alloc_entry
);
    import rv32i_pkg::*;

    opcode_e op;
    logic    rd_used;
    logic    rs1_used;
    logic    rs2_used;

    assign op = opcode_e'(inst[6:0]);

    // which register fields the opcode actually reads or writes
    always_comb begin
        rd_used  = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        case (op)
            op_store: rd_used = 1'b0;
            op_lui, op_auipc, op_jal: begin
                rs1_used = 1'b0;
                rs2_used = 1'b0;
            end
            op_imm, op_load, op_jalr: rs2_used = 1'b0;
            default: ;
        endcase
    end

    // refused outright while the buffer is full
    assign alloc_valid = enqueue_valid && !full;

    always_comb begin
        alloc_entry          = '0;
        alloc_entry.valid    = 1'b1;
        alloc_entry.done     = 1'b0;
        alloc_entry.is_nop   = (inst == nop_inst);
        alloc_entry.pd       = phys_reg;
        alloc_entry.rd_addr  = rd_used  ? arch_reg : '0;
        alloc_entry.rs1_addr = rs1_used ? rs1_s    : '0;
        alloc_entry.rs2_addr = rs2_used ? rs2_s    : '0;
        alloc_entry.regf_we  = regf_we;
        alloc_entry.pc_rdata = pc_rdata;
        alloc_entry.pc_wdata = pc_wdata;
        alloc_entry.inst     = inst;
    end

endmodule : rob_dispatch

// File: rob_ifs.sv
`timescale 1ns/10ps

// completion updates from writeback into the queue
interface rob_cdb_if;
    import rob_cfg_pkg::*;

    // alu slot
    logic             alu_valid;
    rob_idx_t         alu_idx;
    logic [xlen-1:0]  alu_rd_wdata;

    // branch slot
    logic             br_valid;
    rob_idx_t         br_idx;
    logic [xlen-1:0]  br_rd_wdata;
    logic             br_redirect;
    logic [xlen-1:0]  br_redirect_addr;

    modport src (
        output alu_valid, alu_idx, alu_rd_wdata,
        output br_valid, br_idx, br_rd_wdata, br_redirect, br_redirect_addr
    );

    modport dst (
        input alu_valid, alu_idx, alu_rd_wdata,
        input br_valid, br_idx, br_rd_wdata, br_redirect, br_redirect_addr
    );
endinterface : rob_cdb_if

// head of the queue seen by commit
interface rob_head_if;
    import rv32i_pkg::*;

    rob_entry_t  head_entry;
    logic        empty;
    // advances the head by one
    logic        retire;
    // drops every entry
    logic        flush;

    modport dst (
        output head_entry, empty,
        input  retire, flush
    );

    modport src (
        input  head_entry, empty,
        output retire, flush
    );
endinterface : rob_head_if

// File: rv32i_pkg.sv
package rv32i_pkg;

    // major opcodes, low seven bits of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

    // one buffer slot
    typedef struct packed {
        logic                              valid;
        logic                              done;
        logic                              is_nop;
        logic [rob_cfg_pkg::preg_w-1:0]    pd;
        logic [rob_cfg_pkg::areg_w-1:0]    rd_addr;
        logic [rob_cfg_pkg::areg_w-1:0]    rs1_addr;
        logic [rob_cfg_pkg::areg_w-1:0]    rs2_addr;
        logic                              regf_we;
        logic [rob_cfg_pkg::xlen-1:0]      pc_rdata;
        logic [rob_cfg_pkg::xlen-1:0]      pc_wdata;
        logic [rob_cfg_pkg::xlen-1:0]      inst;
        logic [rob_cfg_pkg::xlen-1:0]      rd_wdata;
        // set by a taken branch, acted on at retire
        logic                              redirect;
        logic [rob_cfg_pkg::xlen-1:0]      redirect_addr;
    } rob_entry_t;

endpackage : rv32i_pkg

// File: rob_cfg_pkg.sv
package rob_cfg_pkg;

    // buffer sizing
    localparam int rob_depth = 16;
    localparam int rob_idx_w = $clog2(rob_depth);

    // datapath widths
    localparam int xlen    = 32;
    localparam int order_w = 64;

    // register file addressing
    localparam int preg_w = 6;
    localparam int areg_w = 5;

    // entry index into the buffer
    typedef logic [rob_idx_w-1:0] rob_idx_t;

    // head and tail pointers carry one extra wrap bit
    typedef logic [rob_idx_w:0] rob_ptr_t;

endpackage : rob_cfg_pkg
